/* dataPath.f */
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/specialRegs.sv
hdl/busMux.sv
hdl/aluUnit.sv
hdl/dataPath.sv
testbench/dataPath_checker.sv
testbench/dataPath_tb.sv

/* hdl/aluUnit.sv */
`timescale 1ns/1ps
module aluUnit (
   input  logic                          Clock,
   input  logic                          rst,
   input  logic [cpuPkg::wordWidth-1:0]  busData,
   input  logic                          ryIn,
   input  logic [cpuPkg::opWidth-1:0]    opSelect,
   input  logic                          start,
   output logic                          finished,
   output logic [cpuPkg::wordWidth-1:0]  zHi,
   output logic [cpuPkg::wordWidth-1:0]  zLo
);

   logic [cpuPkg::wordWidth-1:0]          ryReg;      // operand A
   logic [cpuPkg::wordWidth-1:0]          mulA;       // multiplicand held during mul
   logic [2*cpuPkg::wordWidth-1:0]        mulProd;    // {partial sum, remaining multiplier}
   logic [cpuPkg::wordWidth:0]            mulSum;
   logic [$clog2(cpuPkg::mulSteps)-1:0]   stepCount;
   logic                                  busy;
   logic                                  accept;
   logic [cpuPkg::wordWidth-1:0]          opResult;
   logic                                  signExt;    // zHi gets the sign of the result

   assign accept = start && !busy;

   always_ff @(posedge Clock) begin
      if (rst) begin
         ryReg <= '0;
      end else if (ryIn) begin
         ryReg <= busData;
      end
   end

   // single-cycle operations, A from RY and B straight off the bus
   always_comb begin
      signExt = 1'b0;
      case (opSelect)
         cpuPkg::opAdd: begin
            opResult = ryReg + busData;
            signExt  = 1'b1;
         end
         cpuPkg::opSub: begin
            opResult = ryReg - busData;
            signExt  = 1'b1;
         end
         cpuPkg::opAnd: opResult = ryReg & busData;
         cpuPkg::opOr:  opResult = ryReg | busData;
         cpuPkg::opNeg: begin
            opResult = -busData;
            signExt  = 1'b1;
         end
         cpuPkg::opNot: opResult = ~busData;
         cpuPkg::opShl: opResult = ryReg << busData[4:0];
         cpuPkg::opShr: opResult = ryReg >> busData[4:0];
         default:       opResult = '0;
      endcase
   end

   // add the multiplicand into the upper half when the low multiplier bit is set
   assign mulSum = {1'b0, mulProd[2*cpuPkg::wordWidth-1:cpuPkg::wordWidth]}
                 + (mulProd[0] ? {1'b0, mulA} : '0);

   always_ff @(posedge Clock) begin
      mulProd <= {mulSum, mulProd[cpuPkg::wordWidth-1:1]};
      if (accept && opSelect == cpuPkg::opMul) begin
         mulA    <= ryReg;
         mulProd <= {{cpuPkg::wordWidth{1'b0}}, busData};
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         busy      <= 1'b0;
         finished  <= 1'b0;
         stepCount <= '0;
         zHi       <= '0;
         zLo       <= '0;
      end else begin
         finished <= 1'b0;   // one-cycle pulse
         if (accept) begin
            if (opSelect == cpuPkg::opMul) begin
               busy      <= 1'b1;
               stepCount <= '0;
            end else begin
               zLo      <= opResult;
               zHi      <= {cpuPkg::wordWidth{signExt & opResult[cpuPkg::wordWidth-1]}};
               finished <= 1'b1;
            end
         end else if (busy) begin
            stepCount <= stepCount + 1'b1;
            if (stepCount == ($clog2(cpuPkg::mulSteps))'(cpuPkg::mulSteps - 1)) begin
               busy     <= 1'b0;
               finished <= 1'b1;
               {zHi, zLo} <= {mulSum, mulProd[cpuPkg::wordWidth-1:1]};   // last step
            end
         end
      end
   end

endmodule

/* hdl/busMux.sv */
`timescale 1ns/1ps
module busMux (
   input  logic                          rfOut,
   input  logic                          pcOut,
   input  logic                          irOut,
   input  logic                          marOut,
   input  logic                          mdrOut,
   input  logic                          hiOut,
   input  logic                          loOut,
   input  logic                          zHiOut,
   input  logic                          zLoOut,
   input  logic [cpuPkg::wordWidth-1:0]  rfData,
   input  logic [cpuPkg::wordWidth-1:0]  pcData,
   input  logic [cpuPkg::wordWidth-1:0]  irData,
   input  logic [cpuPkg::wordWidth-1:0]  marData,
   input  logic [cpuPkg::wordWidth-1:0]  mdrData,
   input  logic [cpuPkg::wordWidth-1:0]  hiData,
   input  logic [cpuPkg::wordWidth-1:0]  loData,
   input  logic [cpuPkg::wordWidth-1:0]  zHi,
   input  logic [cpuPkg::wordWidth-1:0]  zLo,
   output logic [cpuPkg::wordWidth-1:0]  busData
);

   logic [8:0] outEn;
   logic [3:0] srcSel;
   logic       srcValid;

   assign outEn = {zLoOut, zHiOut, loOut, hiOut, mdrOut, marOut, irOut, pcOut, rfOut};

   // encoder, scanning downward so the lowest set index is kept
   always_comb begin
      srcSel   = '0;
      srcValid = 1'b0;
      for (int i = 8; i >= 0; i--) begin
         if (outEn[i]) begin
            srcSel   = 4'(i);
            srcValid = 1'b1;
         end
      end
   end

   always_comb begin
      busData = '0;   // idle bus reads zero
      if (srcValid) begin
         case (srcSel)
            4'd0:    busData = rfData;
            4'd1:    busData = pcData;
            4'd2:    busData = irData;
            4'd3:    busData = marData;
            4'd4:    busData = mdrData;
            4'd5:    busData = hiData;
            4'd6:    busData = loData;
            4'd7:    busData = zHi;
            4'd8:    busData = zLo;
            default: busData = '0;
         endcase
      end
   end

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

   // datapath sizes
   localparam int wordWidth = 32;   // data word and bus width
   localparam int regCount  = 32;   // general registers R0..R31
   localparam int selWidth  = 5;    // register select width
   localparam int opWidth   = 5;    // ALU operation code width

   // ALU operation codes
   // neg keeps the encoding of the older instruction set
   localparam logic [opWidth-1:0] opAdd = 5'b00011;
   localparam logic [opWidth-1:0] opSub = 5'b00100;
   localparam logic [opWidth-1:0] opAnd = 5'b00101;
   localparam logic [opWidth-1:0] opOr  = 5'b00110;
   localparam logic [opWidth-1:0] opNeg = 5'b00111;
   localparam logic [opWidth-1:0] opNot = 5'b01000;
   localparam logic [opWidth-1:0] opShl = 5'b01001;
   localparam logic [opWidth-1:0] opShr = 5'b01010;
   localparam logic [opWidth-1:0] opMul = 5'b01011;

   // one multiplier bit is retired per step
   localparam int mulSteps = 32;

endpackage

/* hdl/dataPath.sv */
`timescale 1ns/1ps
module dataPath (
   input  logic                          Clock,
   input  logic                          rst,
   input  logic                          rfOut,
   input  logic                          pcOut,
   input  logic                          irOut,
   input  logic                          marOut,
   input  logic                          mdrOut,
   input  logic                          hiOut,
   input  logic                          loOut,
   input  logic                          zHiOut,
   input  logic                          zLoOut,
   input  logic                          rfIn,
   input  logic                          pcIn,
   input  logic                          irIn,
   input  logic                          marIn,
   input  logic                          mdrIn,
   input  logic                          hiIn,
   input  logic                          loIn,
   input  logic                          ryIn,
   input  logic [cpuPkg::selWidth-1:0]   rfSelect,
   input  logic                          read,
   input  logic                          incPc,
   input  logic [cpuPkg::wordWidth-1:0]  memData,
   input  logic [cpuPkg::opWidth-1:0]    opSelect,
   input  logic                          start,
   output logic                          finished,
   output logic [cpuPkg::wordWidth-1:0]  busData,
   output logic [cpuPkg::wordWidth-1:0]  address
);

   logic [cpuPkg::wordWidth-1:0] rfData;
   logic [cpuPkg::wordWidth-1:0] pcData;
   logic [cpuPkg::wordWidth-1:0] irData;
   logic [cpuPkg::wordWidth-1:0] mdrData;
   logic [cpuPkg::wordWidth-1:0] hiData;
   logic [cpuPkg::wordWidth-1:0] loData;
   logic [cpuPkg::wordWidth-1:0] zHi;
   logic [cpuPkg::wordWidth-1:0] zLo;

   regFile rf0 (.Clock, .rst, .rfSelect, .rfIn, .busData, .rfData);

   // MAR drives the address port and feeds the bus mux as well
   specialRegs sr0 (
      .Clock, .rst, .busData, .memData, .read,
      .pcIn, .incPc, .irIn, .marIn, .mdrIn, .hiIn, .loIn,
      .pcData, .irData, .marData(address), .mdrData, .hiData, .loData
   );

   busMux mux0 (
      .rfOut, .pcOut, .irOut, .marOut, .mdrOut, .hiOut, .loOut, .zHiOut, .zLoOut,
      .rfData, .pcData, .irData, .marData(address), .mdrData, .hiData, .loData,
      .zHi, .zLo, .busData
   );

   aluUnit alu0 (
      .Clock, .rst, .busData, .ryIn, .opSelect, .start, .finished, .zHi, .zLo
   );

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps
module regFile (
   input  logic                          Clock,
   input  logic                          rst,
   input  logic [cpuPkg::selWidth-1:0]   rfSelect,
   input  logic                          rfIn,
   input  logic [cpuPkg::wordWidth-1:0]  busData,
   output logic [cpuPkg::wordWidth-1:0]  rfData
);

   logic [cpuPkg::wordWidth-1:0] regs [cpuPkg::regCount];

   // R0 is never written, so after reset it reads as zero for good
   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < cpuPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (rfIn && (rfSelect != '0)) begin
         regs[rfSelect] <= busData;
      end
   end

   assign rfData = regs[rfSelect];   // combinational read

endmodule

/* hdl/specialRegs.sv */
`timescale 1ns/1ps
module specialRegs (
   input  logic                          Clock,
   input  logic                          rst,
   input  logic [cpuPkg::wordWidth-1:0]  busData,
   input  logic [cpuPkg::wordWidth-1:0]  memData,
   input  logic                          read,
   input  logic                          pcIn,
   input  logic                          incPc,
   input  logic                          irIn,
   input  logic                          marIn,
   input  logic                          mdrIn,
   input  logic                          hiIn,
   input  logic                          loIn,
   output logic [cpuPkg::wordWidth-1:0]  pcData,
   output logic [cpuPkg::wordWidth-1:0]  irData,
   output logic [cpuPkg::wordWidth-1:0]  marData,
   output logic [cpuPkg::wordWidth-1:0]  mdrData,
   output logic [cpuPkg::wordWidth-1:0]  hiData,
   output logic [cpuPkg::wordWidth-1:0]  loData
);

   logic [cpuPkg::wordWidth-1:0] mdrNext;

   // memory read data takes the MDR while read is high
   assign mdrNext = read ? memData : busData;

   // program counter, a bus load wins over the increment
   always_ff @(posedge Clock) begin
      if (rst) begin
         pcData <= '0;
      end else if (pcIn) begin
         pcData <= busData;
      end else if (incPc) begin
         pcData <= pcData + cpuPkg::wordWidth'(4);   // next word
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         irData  <= '0;
         marData <= '0;
         mdrData <= '0;
         hiData  <= '0;
         loData  <= '0;
      end else begin
         if (irIn) begin
            irData <= busData;
         end
         if (marIn) begin
            marData <= busData;   // also the memory address
         end
         if (mdrIn) begin
            mdrData <= mdrNext;
         end
         if (hiIn) begin
            hiData <= busData;
         end
         if (loIn) begin
            loData <= busData;
         end
      end
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the dataPath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module dataPath_tb -f dataPath.f -o simv
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF "** FAIL **" sim.log; then
   echo "failure reported in sim.log"
   exit 1
fi
exit 0

/* testbench/dataPath_checker.sv */
`timescale 1ns/1ps
module dataPath_checker (
   input logic                          Clock,
   input logic                          rst,
   input logic [cpuPkg::wordWidth-1:0]  busData,
   input logic                          start,
   input logic                          finished,
   input logic [cpuPkg::opWidth-1:0]    opSelect,
   input logic [8:0]                    outEn,
   input logic [cpuPkg::wordWidth-1:0]  zHi,
   input logic [cpuPkg::wordWidth-1:0]  zLo,
   input logic [cpuPkg::wordWidth-1:0]  ryReg,
   input logic                          busy
);

   logic [cpuPkg::wordWidth-1:0] capA;
   logic [cpuPkg::wordWidth-1:0] capB;
   logic [cpuPkg::opWidth-1:0]   capOp;
   logic                         lastMul;
   logic [7:0]                   sinceStart;   // cycles since the last accepted start
   logic                         accept;
   int                           failCount = 0;

   assign accept = start && !busy;

   // Z contents for a single-cycle operation
   function automatic logic [63:0] ruleResult(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
      logic [31:0] lo;
      logic        ext;
      lo  = '0;
      ext = 1'b0;
      case (op)
         cpuPkg::opAdd: begin
            lo  = a + b;
            ext = 1'b1;
         end
         cpuPkg::opSub: begin
            lo  = a - b;
            ext = 1'b1;
         end
         cpuPkg::opAnd: lo = a & b;
         cpuPkg::opOr:  lo = a | b;
         cpuPkg::opNeg: begin
            lo  = 32'd0 - b;
            ext = 1'b1;
         end
         cpuPkg::opNot: lo = ~b;
         cpuPkg::opShl: lo = a << b[4:0];
         cpuPkg::opShr: lo = a >> b[4:0];
         default:       lo = '0;
      endcase
      return {{32{ext & lo[31]}}, lo};
   endfunction

   always_ff @(posedge Clock) begin
      if (rst) begin
         sinceStart <= '0;
         lastMul    <= 1'b0;
      end else if (accept) begin
         capA       <= ryReg;   // operand A from RY
         capB       <= busData; // operand B from the bus
         capOp      <= opSelect;
         lastMul    <= (opSelect == cpuPkg::opMul);
         sinceStart <= 8'd1;
      end else if (sinceStart != 8'd0 && sinceStart != 8'hFF) begin
         sinceStart <= sinceStart + 8'd1;
      end
   end

   aluRule: assert property (@(posedge Clock) disable iff (rst)
      (finished && !lastMul) |-> ({zHi, zLo} == ruleResult(capOp, capA, capB)))
      else begin
         failCount++;
         $error("single-cycle ALU result does not follow its rule");
      end

   mulRule: assert property (@(posedge Clock) disable iff (rst)
      (finished && lastMul) |-> ({zHi, zLo} == 64'(capA) * 64'(capB)))
      else begin
         failCount++;
         $error("multiply result is not the unsigned product");
      end

   shortLatency: assert property (@(posedge Clock) disable iff (rst)
      (accept && opSelect != cpuPkg::opMul) |=> finished)
      else begin
         failCount++;
         $error("finished missing one cycle after start");
      end

   finishTiming: assert property (@(posedge Clock) disable iff (rst)
      finished |-> (sinceStart == (lastMul ? 8'(cpuPkg::mulSteps + 1) : 8'd1)))
      else begin
         failCount++;
         $error("finished at the wrong distance from start");
      end

   mulLatency: assert property (@(posedge Clock) disable iff (rst)
      (lastMul && sinceStart == 8'(cpuPkg::mulSteps + 1)) |-> finished)
      else begin
         failCount++;
         $error("multiply did not finish after mulSteps+1 cycles");
      end

   busOwner: assert property (@(posedge Clock) disable iff (rst) $onehot0(outEn))
      else begin
         failCount++;
         $error("more than one bus source enabled");
      end

   resetQuiet: assert property (@(posedge Clock) (rst && $past(rst)) |-> !finished)
      else begin
         failCount++;
         $error("finished high during reset");
      end

endmodule

bind dataPath dataPath_checker chk0 (
   .Clock, .rst, .busData, .start, .finished, .opSelect,
   .outEn({zLoOut, zHiOut, loOut, hiOut, mdrOut, marOut, irOut, pcOut, rfOut}),
   .zHi, .zLo, .ryReg(alu0.ryReg), .busy(alu0.busy)
);

/* testbench/dataPath_tb.sv */
`timescale 1ns/1ps
module dataPath_tb;

   typedef enum int {srcRf, srcPc, srcIr, srcMar, srcMdr, srcHi, srcLo, srcZHi, srcZLo} srcType;
   typedef enum int {dstRf, dstPc, dstIr, dstMar, dstMdr, dstHi, dstLo, dstRy} dstType;

   logic        Clock = 1'b0;
   logic        rst;
   logic [8:0]  outEn;   // same order as the bus mux sources
   logic [7:0]  inEn;
   logic        read;
   logic        incPc;
   logic        start;
   logic [4:0]  rfSelect;
   logic [4:0]  opSelect;
   logic [31:0] memData;
   logic        finished;
   logic [31:0] busData;
   logic [31:0] address;
   logic [31:0] rngState = 32'd81616;
   logic [4:0]  singleOps [8] = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                                  cpuPkg::opNeg, cpuPkg::opNot, cpuPkg::opShl, cpuPkg::opShr};
   int          numTests = 6;
   int          errors = 0;
   int          testsRun = 0;
   int          testsFailed = 0;
   int          failsSeen = 0;

   dataPath dut0 (
      .Clock, .rst,
      .rfOut(outEn[0]), .pcOut(outEn[1]), .irOut(outEn[2]), .marOut(outEn[3]),
      .mdrOut(outEn[4]), .hiOut(outEn[5]), .loOut(outEn[6]), .zHiOut(outEn[7]),
      .zLoOut(outEn[8]),
      .rfIn(inEn[0]), .pcIn(inEn[1]), .irIn(inEn[2]), .marIn(inEn[3]), .mdrIn(inEn[4]),
      .hiIn(inEn[5]), .loIn(inEn[6]), .ryIn(inEn[7]),
      .rfSelect, .read, .incPc, .memData, .opSelect, .start, .finished, .busData, .address
   );

   always #5 Clock = ~Clock;

   function automatic logic [31:0] nextRand();   // xorshift32
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   function automatic int failTotal();
      return errors + dut0.chk0.failCount;
   endfunction

   task automatic clearCtl();
      outEn    = '0;
      inEn     = '0;
      read     = 1'b0;
      incPc    = 1'b0;
      start    = 1'b0;
      rfSelect = '0;
      opSelect = '0;
      memData  = '0;
   endtask

   task automatic nextCycle();   // one micro-step ends at the edge
      @(posedge Clock);
      #1;
      clearCtl();
   endtask

   task automatic move(input int src, input int dst, input int r);
      rfSelect   = 5'(r);
      outEn[src] = 1'b1;
      inEn[dst]  = 1'b1;
      nextCycle();
   endtask

   task automatic loadReg(input int r, input logic [31:0] v);
      memData      = v;
      read         = 1'b1;
      inEn[dstMdr] = 1'b1;
      nextCycle();
      move(srcMdr, dstRf, r);
   endtask

   task automatic readBack(input int src, input int r, output logic [31:0] v);
      rfSelect   = 5'(r);
      outEn[src] = 1'b1;
      #4 v = busData;   // mid-cycle, bus settled
      nextCycle();
   endtask

   task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] want);
      assert (got == want) else begin
         $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, want);
         errors++;
      end
   endtask

   task automatic aluRun(input logic [4:0] op, input int ra, input int rb, input bit restart);
      int n;
      move(srcRf, dstRy, ra);
      rfSelect      = 5'(rb);
      outEn[srcRf]  = 1'b1;
      opSelect      = op;
      start         = 1'b1;
      nextCycle();
      if (restart) begin
         outEn[srcRf] = 1'b1;   // this start lands while busy
         opSelect     = cpuPkg::opAdd;
         start        = 1'b1;
         nextCycle();
      end
      n = 0;
      while (finished !== 1'b1 && n < 100) begin
         @(posedge Clock);
         #1;
         n++;
      end
      if (n == 100) begin
         $display("ALU op %b never raised finished", op);
         errors++;
      end
   endtask

   task automatic report(input string name);
      nextCycle();   // the checker looks at the last finished on this edge
      testsRun++;
      if (failTotal() != failsSeen) begin
         testsFailed++;
         $display("test %0d %s: failed", testsRun, name);
      end else begin
         $display("test %0d %s: passed", testsRun, name);
      end
      failsSeen = failTotal();
   endtask

   initial begin
      logic [31:0] v;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] shadow [32];
      logic [31:0] used;
      logic [63:0] prod;
      int          r;
      clearCtl();
      rst = 1'b1;
      repeat (4) @(posedge Clock);
      #1 rst = 1'b0;

      expectEq("idle bus", busData, 32'd0);
      expectEq("finished after reset", 32'(finished), 32'd0);
      for (int i = 0; i < cpuPkg::regCount; i++) begin
         readBack(srcRf, i, v);
         expectEq("general register after reset", v, 32'd0);
      end
      for (int s = srcPc; s <= srcZLo; s++) begin
         readBack(s, 0, v);
         expectEq("special register after reset", v, 32'd0);
      end
      report("reset state");

      used = '0;
      for (int k = 0; k < 8; k++) begin
         r = int'(nextRand() % 32'd31) + 1;   // R1..R31
         v = nextRand();
         loadReg(r, v);
         shadow[r] = v;
         used[r]   = 1'b1;
      end
      for (int i = 1; i < cpuPkg::regCount; i++) begin
         if (used[i]) begin
            readBack(srcRf, i, v);
            expectEq("register readback", v, shadow[i]);
         end
      end
      loadReg(0, nextRand());
      readBack(srcRf, 0, v);
      expectEq("R0 after write", v, 32'd0);
      report("register file");

      loadReg(7, 32'h12);
      loadReg(6, 32'h18);
      aluRun(cpuPkg::opNeg, 7, 6, 1'b0);
      move(srcZLo, dstRf, 6);
      readBack(srcRf, 6, v);
      expectEq("R6 after negate", v, 32'hFFFF_FFE8);
      report("negate");

      foreach (singleOps[k]) begin
         loadReg(1, nextRand());
         loadReg(2, nextRand());
         aluRun(singleOps[k], 1, 2, 1'b0);
      end
      report("single-cycle ops");

      a    = nextRand();
      b    = nextRand();
      prod = 64'(a) * 64'(b);
      loadReg(3, a);
      loadReg(4, b);
      aluRun(cpuPkg::opMul, 3, 4, 1'b1);
      move(srcZHi, dstHi, 0);
      move(srcZLo, dstLo, 0);
      readBack(srcHi, 0, v);
      expectEq("HI after multiply", v, prod[63:32]);
      readBack(srcLo, 0, v);
      expectEq("LO after multiply", v, prod[31:0]);
      report("multiply");

      a = nextRand() & 32'hFFFF_FFFC;
      loadReg(5, a);
      move(srcRf, dstPc, 5);
      repeat (2) begin
         incPc = 1'b1;
         nextCycle();
      end
      readBack(srcPc, 0, v);
      expectEq("PC after two increments", v, a + 32'd8);
      b = nextRand();
      loadReg(9, b);
      move(srcRf, dstMar, 9);
      expectEq("address from MAR", address, b);
      report("PC and MAR");

      $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, failTotal());
      if (failTotal() == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   initial begin
      #((numTests * 60 + 200) * 10);
      $display("simulation timed out before all tests finished");
      $display("** FAIL **");
      $finish;
   end

endmodule
